//--- source/cpuDefs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// Machine word and register file size
`define DATA_WIDTH 32
`define REG_COUNT 32

// First fetch address, NPC starts one word later
`define RESET_PC 32'h0000_0000

// Top bit of each instruction field
`define OP_HI 31
`define OP3_HI 24
`define RD_HI 29
`define RS1_HI 18
`define I_BIT 13
`define COND_HI 28
`define ANNUL_BIT 29

`endif

//--- source/cpuPkg.sv
package cpuPkg;

	// ALU operations
	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_PASSB
	} aluOpT;

	// ALU A operand source
	typedef enum logic [1:0] {
		A_RS1,
		A_PC,
		A_NPC
	} aluASelT;

	// ALU B operand source
	typedef enum logic [2:0] {
		B_RS2,
		B_SIMM13,
		B_SETHI,
		B_DISP,
		B_FOUR
	} aluBSelT;

	typedef enum logic {
		PC_FROM_NPC,
		PC_FROM_ALU
	} pcSrcT;

	typedef enum logic [1:0] {
		BUS_FETCH,
		BUS_LOAD,
		BUS_STORE
	} busOpT;

	// Control sequencer states
	typedef enum logic [4:0] {
		S_RESET,
		S_FETCH,
		S_FETCH_WAIT,
		S_DECODE,
		S_ALU_EXEC,
		S_ALU_WB,
		S_ADDR,
		S_LD_REQ,
		S_LD_WAIT,
		S_LD_WB,
		S_ST_REQ,
		S_ST_WAIT,
		S_BRANCH,
		S_BR_UPD,
		S_NEXT_PC,
		S_HALT
	} ctrlStateT;

	// Integer condition codes
	typedef struct packed {
		logic n;
		logic z;
		logic v;
		logic c;
	} iccT;

endpackage

//--- source/apbBusMaster.sv
`include "cpuDefs.svh"

module apbBusMaster
	import cpuPkg::*;
(
	input logic Clk,
	input logic RESET,
	input logic memReq,
	input busOpT memOp,
	input logic [`DATA_WIDTH-1:0] memAddr,
	input logic [`DATA_WIDTH-1:0] memWdata,
	output logic [`DATA_WIDTH-1:0] memRdata,
	output logic memDone,
	output logic [`DATA_WIDTH-1:0] paddr,
	output logic [`DATA_WIDTH-1:0] pwdata,
	output logic pwrite,
	output logic psel,
	output logic penable,
	input logic [`DATA_WIDTH-1:0] prdata,
	input logic pready
);

	typedef enum logic [1:0] {
		IDLE,
		SETUP,
		ACCESS
	} apbStateT;

	apbStateT state;
	logic acceptReq;

	assign acceptReq = memReq && (state == IDLE);

	always_ff @(posedge Clk)
	begin
		if (RESET)
		begin
			state <= IDLE;
			pwrite <= 1'b0;
		end
		else
		begin
			case (state)
				IDLE:
				begin
					if (memReq)
						state <= SETUP;
				end
				SETUP:
					state <= ACCESS;
				// Held here for as long as the slave stalls
				ACCESS:
				begin
					if (pready)
						state <= IDLE;
				end
				default:
					state <= IDLE;
			endcase
			if (acceptReq)
				pwrite <= (memOp == BUS_STORE);
		end
	end

	// Latched at the request, stable until completion
	always_ff @(posedge Clk)
	begin
		if (acceptReq)
		begin
			paddr <= memAddr;
			pwdata <= memWdata;
		end
	end

	assign psel = (state != IDLE);
	assign penable = (state == ACCESS);

	// Completion cycle, read data passed straight through
	assign memDone = (state == ACCESS) && pready;
	assign memRdata = prdata;

	assert property (@(posedge Clk) disable iff (RESET) penable |-> psel);

	assert property (@(posedge Clk) disable iff (RESET)
		psel && !(penable && pready) |=> psel && $stable(paddr));

endmodule

//--- source/controlUnit.sv
`include "cpuDefs.svh"

module controlUnit
	import cpuPkg::*;
(
	input logic Clk,
	input logic RESET,
	input logic [`DATA_WIDTH-1:0] ir,
	input logic branchTaken,
	input logic memDone,
	output logic pcLoad,
	output logic npcLoad,
	output logic irLoad,
	output logic marLoad,
	output logic mdrLoad,
	output logic iccLoad,
	output logic regWrite,
	output logic memReq,
	output aluOpT aluOp,
	output aluASelT aluASel,
	output aluBSelT aluBSel,
	output pcSrcT pcSrc,
	output busOpT memOp,
	output logic halted
);

	ctrlStateT state;
	ctrlStateT nextState;

	logic [1:0] op;
	logic [2:0] op2;
	logic [5:0] op3;
	logic [3:0] cond;
	logic validArith;
	logic validBranch;
	aluOpT decodedOp;
	aluOpT arithOp;
	aluBSelT regOrImm;

	assign op = ir[`OP_HI -: 2];
	assign op2 = ir[`OP3_HI -: 3];
	assign op3 = ir[`OP3_HI -: 6];
	assign cond = ir[`COND_HI -: 4];

	// Only BN, BE, BA and BNE without annul
	assign validBranch = !ir[`ANNUL_BIT] && (cond[2:1] == 2'b00);

	assign regOrImm = ir[`I_BIT] ? B_SIMM13 : B_RS2;

	// op3 bit 4 marks the cc form, bits 2:0 the operation
	always_comb
	begin
		validArith = !op3[5] && !op3[3];
		case (op3[2:0])
			3'b000: decodedOp = ALU_ADD;
			3'b001: decodedOp = ALU_AND;
			3'b010: decodedOp = ALU_OR;
			3'b011: decodedOp = ALU_XOR;
			3'b100: decodedOp = ALU_SUB;
			default:
			begin
				decodedOp = ALU_ADD;
				validArith = 1'b0;
			end
		endcase
	end

	// SETHI just passes its immediate through
	assign arithOp = (op == 2'b00) ? ALU_PASSB : decodedOp;

	always_ff @(posedge Clk)
	begin
		if (RESET)
			state <= S_RESET;
		else
			state <= nextState;
	end

	always_comb
	begin
		nextState = state;
		pcLoad = 1'b0;
		npcLoad = 1'b0;
		irLoad = 1'b0;
		marLoad = 1'b0;
		mdrLoad = 1'b0;
		iccLoad = 1'b0;
		regWrite = 1'b0;
		memReq = 1'b0;
		memOp = BUS_FETCH;
		aluOp = ALU_ADD;
		aluASel = A_RS1;
		aluBSel = B_RS2;
		pcSrc = PC_FROM_NPC;

		case (state)
			S_RESET:
				nextState = S_FETCH;
			S_FETCH:
			begin
				memReq = 1'b1;
				nextState = S_FETCH_WAIT;
			end
			S_FETCH_WAIT:
			begin
				if (memDone)
				begin
					irLoad = 1'b1;
					nextState = S_DECODE;
				end
			end
			S_DECODE:
			begin
				case (op)
					2'b00:
					begin
						if (op2 == 3'b100)
							nextState = S_ALU_EXEC;
						else if (op2 == 3'b010 && validBranch)
							nextState = S_BRANCH;
						else
							nextState = S_HALT;
					end
					2'b10:
						nextState = validArith ? S_ALU_EXEC : S_HALT;
					// Word LD and ST only
					2'b11:
					begin
						if (op3 == 6'b000000 || op3 == 6'b000100)
							nextState = S_ADDR;
						else
							nextState = S_HALT;
					end
					default:
						nextState = S_HALT;
				endcase
			end
			// Operands settle before the write
			S_ALU_EXEC:
			begin
				aluOp = arithOp;
				aluBSel = (op == 2'b00) ? B_SETHI : regOrImm;
				nextState = S_ALU_WB;
			end
			S_ALU_WB:
			begin
				aluOp = arithOp;
				aluBSel = (op == 2'b00) ? B_SETHI : regOrImm;
				regWrite = 1'b1;
				iccLoad = (op == 2'b10) && op3[4];
				nextState = S_NEXT_PC;
			end
			// Effective address rs1 + rs2 or simm13
			S_ADDR:
			begin
				aluBSel = regOrImm;
				marLoad = 1'b1;
				nextState = op3[2] ? S_ST_REQ : S_LD_REQ;
			end
			S_LD_REQ:
			begin
				memReq = 1'b1;
				memOp = BUS_LOAD;
				nextState = S_LD_WAIT;
			end
			S_LD_WAIT:
			begin
				memOp = BUS_LOAD;
				if (memDone)
				begin
					mdrLoad = 1'b1;
					nextState = S_LD_WB;
				end
			end
			S_LD_WB:
			begin
				regWrite = 1'b1;
				nextState = S_NEXT_PC;
			end
			S_ST_REQ:
			begin
				memReq = 1'b1;
				memOp = BUS_STORE;
				nextState = S_ST_WAIT;
			end
			S_ST_WAIT:
			begin
				memOp = BUS_STORE;
				if (memDone)
					nextState = S_NEXT_PC;
			end
			// NPC gets PC + disp when taken, NPC + 4 otherwise
			S_BRANCH:
			begin
				aluASel = branchTaken ? A_PC : A_NPC;
				aluBSel = branchTaken ? B_DISP : B_FOUR;
				nextState = S_BR_UPD;
			end
			S_BR_UPD:
			begin
				aluASel = branchTaken ? A_PC : A_NPC;
				aluBSel = branchTaken ? B_DISP : B_FOUR;
				pcLoad = 1'b1;
				npcLoad = 1'b1;
				nextState = S_FETCH;
			end
			// PC <- NPC, NPC <- NPC + 4
			S_NEXT_PC:
			begin
				aluASel = A_NPC;
				aluBSel = B_FOUR;
				pcLoad = 1'b1;
				npcLoad = 1'b1;
				nextState = S_FETCH;
			end
			S_HALT:
				nextState = S_HALT;
			default:
				nextState = S_HALT;
		endcase
	end

	assign halted = (state == S_HALT);

	assert property (@(posedge Clk) disable iff (RESET) !(pcLoad && irLoad));

endmodule

//--- source/regFile.sv
`include "cpuDefs.svh"

module regFile
	import cpuPkg::*;
(
	input logic Clk,
	input logic RESET,
	input logic [4:0] rs1Addr,
	input logic [4:0] rs2Addr,
	input logic [4:0] rdAddr,
	input logic writeEn,
	input logic [`DATA_WIDTH-1:0] writeData,
	output logic [`DATA_WIDTH-1:0] rs1Data,
	output logic [`DATA_WIDTH-1:0] rs2Data,
	output logic [`DATA_WIDTH-1:0] rdData
);

	logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];

	// Writes to r0 are dropped, none while in reset
	always_ff @(posedge Clk)
	begin
		if (writeEn && !RESET && rdAddr != 5'd0)
			regs[rdAddr] <= writeData;
	end

	// r0 reads as zero
	assign rs1Data = (rs1Addr == 5'd0) ? '0 : regs[rs1Addr];
	assign rs2Data = (rs2Addr == 5'd0) ? '0 : regs[rs2Addr];

	// Store data port
	assign rdData = (rdAddr == 5'd0) ? '0 : regs[rdAddr];

endmodule

//--- source/alu.sv
`include "cpuDefs.svh"

module alu
	import cpuPkg::*;
(
	input logic [`DATA_WIDTH-1:0] a,
	input logic [`DATA_WIDTH-1:0] b,
	input aluOpT aluOp,
	output logic [`DATA_WIDTH-1:0] result,
	output iccT flags
);

	logic [`DATA_WIDTH:0] sum;
	logic [`DATA_WIDTH:0] diff;

	// Extra top bit holds carry or borrow
	assign sum = {1'b0, a} + {1'b0, b};
	assign diff = {1'b0, a} - {1'b0, b};

	always_comb
	begin
		flags.v = 1'b0;
		flags.c = 1'b0;
		case (aluOp)
			ALU_ADD:
			begin
				result = sum[`DATA_WIDTH-1:0];
				flags.c = sum[`DATA_WIDTH];
				flags.v = (a[`DATA_WIDTH-1] == b[`DATA_WIDTH-1])
					&& (result[`DATA_WIDTH-1] != a[`DATA_WIDTH-1]);
			end
			// C is the borrow, set when a < b unsigned
			ALU_SUB:
			begin
				result = diff[`DATA_WIDTH-1:0];
				flags.c = diff[`DATA_WIDTH];
				flags.v = (a[`DATA_WIDTH-1] != b[`DATA_WIDTH-1])
					&& (result[`DATA_WIDTH-1] != a[`DATA_WIDTH-1]);
			end
			ALU_AND:
				result = a & b;
			ALU_OR:
				result = a | b;
			ALU_XOR:
				result = a ^ b;
			ALU_PASSB:
				result = b;
			default:
				result = '0;
		endcase
		flags.n = result[`DATA_WIDTH-1];
		flags.z = (result == '0);
	end

endmodule

//--- source/dataPath.sv
`include "cpuDefs.svh"

module dataPath
	import cpuPkg::*;
(
	input logic Clk,
	input logic RESET,
	input logic pcLoad,
	input logic npcLoad,
	input logic irLoad,
	input logic marLoad,
	input logic mdrLoad,
	input logic iccLoad,
	input logic regWrite,
	input aluOpT aluOp,
	input aluASelT aluASel,
	input aluBSelT aluBSel,
	input pcSrcT pcSrc,
	input busOpT memOp,
	input logic [`DATA_WIDTH-1:0] memRdata,
	output logic [`DATA_WIDTH-1:0] ir,
	output logic branchTaken,
	output logic [`DATA_WIDTH-1:0] memAddr,
	output logic [`DATA_WIDTH-1:0] memWdata
);

	logic [`DATA_WIDTH-1:0] pc;
	logic [`DATA_WIDTH-1:0] npc;
	logic [`DATA_WIDTH-1:0] mar;
	logic [`DATA_WIDTH-1:0] mdr;
	iccT icc;
	iccT aluFlags;
	logic [`DATA_WIDTH-1:0] rs1Data;
	logic [`DATA_WIDTH-1:0] rs2Data;
	logic [`DATA_WIDTH-1:0] aluA;
	logic [`DATA_WIDTH-1:0] aluB;
	logic [`DATA_WIDTH-1:0] aluResult;
	logic [`DATA_WIDTH-1:0] writeData;
	logic [`DATA_WIDTH-1:0] simm13;
	logic [`DATA_WIDTH-1:0] sethiImm;
	logic [`DATA_WIDTH-1:0] dispWord;

	assign simm13 = {{19{ir[12]}}, ir[12:0]};
	assign sethiImm = {ir[21:0], 10'b0};
	// disp22 counts words
	assign dispWord = {{8{ir[21]}}, ir[21:0], 2'b00};

	always_ff @(posedge Clk)
	begin
		if (RESET)
		begin
			pc <= `RESET_PC;
			npc <= `RESET_PC + 4;
			ir <= '0;
			icc <= '0;
		end
		else
		begin
			if (pcLoad)
				pc <= (pcSrc == PC_FROM_ALU) ? aluResult : npc;
			if (npcLoad)
				npc <= aluResult;
			if (irLoad)
				ir <= memRdata;
			if (iccLoad)
				icc <= aluFlags;
		end
	end

	always_ff @(posedge Clk)
	begin
		if (marLoad)
			mar <= aluResult;
		if (mdrLoad)
			mdr <= memRdata;
	end

	always_comb
	begin
		case (aluASel)
			A_PC: aluA = pc;
			A_NPC: aluA = npc;
			default: aluA = rs1Data;
		endcase
		case (aluBSel)
			B_SIMM13: aluB = simm13;
			B_SETHI: aluB = sethiImm;
			B_DISP: aluB = dispWord;
			B_FOUR: aluB = 32'd4;
			default: aluB = rs2Data;
		endcase
	end

	// BN falls in the default and never branches
	always_comb
	begin
		case (ir[`COND_HI -: 4])
			4'b0001: branchTaken = icc.z;
			4'b1000: branchTaken = 1'b1;
			4'b1001: branchTaken = !icc.z;
			default: branchTaken = 1'b0;
		endcase
	end

	// Loads write back from MDR
	assign writeData = (ir[`OP_HI -: 2] == 2'b11) ? mdr : aluResult;

	assign memAddr = (memOp == BUS_FETCH) ? pc : mar;

	regFile regs (
		.Clk(Clk),
		.RESET(RESET),
		.rs1Addr(ir[`RS1_HI -: 5]),
		.rs2Addr(ir[4:0]),
		.rdAddr(ir[`RD_HI -: 5]),
		.writeEn(regWrite),
		.writeData(writeData),
		.rs1Data(rs1Data),
		.rs2Data(rs2Data),
		.rdData(memWdata)
	);

	alu aluUnit (
		.a(aluA),
		.b(aluB),
		.aluOp(aluOp),
		.result(aluResult),
		.flags(aluFlags)
	);

endmodule

//--- source/cpuTop.sv
`include "cpuDefs.svh"

module cpuTop
	import cpuPkg::*;
(
	input logic Clk,
	input logic RESET,
	output logic [`DATA_WIDTH-1:0] paddr,
	output logic [`DATA_WIDTH-1:0] pwdata,
	output logic pwrite,
	output logic psel,
	output logic penable,
	input logic [`DATA_WIDTH-1:0] prdata,
	input logic pready,
	output logic halted
);

	logic memReq;
	logic memDone;
	busOpT memOp;
	logic [`DATA_WIDTH-1:0] memAddr;
	logic [`DATA_WIDTH-1:0] memWdata;
	logic [`DATA_WIDTH-1:0] memRdata;
	logic [`DATA_WIDTH-1:0] ir;
	logic branchTaken;
	logic pcLoad;
	logic npcLoad;
	logic irLoad;
	logic marLoad;
	logic mdrLoad;
	logic iccLoad;
	logic regWrite;
	aluOpT aluOp;
	aluASelT aluASel;
	aluBSelT aluBSel;
	pcSrcT pcSrc;

	apbBusMaster bus (
		.Clk(Clk),
		.RESET(RESET),
		.memReq(memReq),
		.memOp(memOp),
		.memAddr(memAddr),
		.memWdata(memWdata),
		.memRdata(memRdata),
		.memDone(memDone),
		.paddr(paddr),
		.pwdata(pwdata),
		.pwrite(pwrite),
		.psel(psel),
		.penable(penable),
		.prdata(prdata),
		.pready(pready)
	);

	controlUnit ctrl (
		.Clk(Clk),
		.RESET(RESET),
		.ir(ir),
		.branchTaken(branchTaken),
		.memDone(memDone),
		.pcLoad(pcLoad),
		.npcLoad(npcLoad),
		.irLoad(irLoad),
		.marLoad(marLoad),
		.mdrLoad(mdrLoad),
		.iccLoad(iccLoad),
		.regWrite(regWrite),
		.memReq(memReq),
		.aluOp(aluOp),
		.aluASel(aluASel),
		.aluBSel(aluBSel),
		.pcSrc(pcSrc),
		.memOp(memOp),
		.halted(halted)
	);

	dataPath dp (
		.Clk(Clk),
		.RESET(RESET),
		.pcLoad(pcLoad),
		.npcLoad(npcLoad),
		.irLoad(irLoad),
		.marLoad(marLoad),
		.mdrLoad(mdrLoad),
		.iccLoad(iccLoad),
		.regWrite(regWrite),
		.aluOp(aluOp),
		.aluASel(aluASel),
		.aluBSel(aluBSel),
		.pcSrc(pcSrc),
		.memOp(memOp),
		.memRdata(memRdata),
		.ir(ir),
		.branchTaken(branchTaken),
		.memAddr(memAddr),
		.memWdata(memWdata)
	);

endmodule

//--- verif/apbMemoryModel.sv
`include "cpuDefs.svh"

module apbMemoryModel
	import cpuPkg::*;
(
	input logic Clk,
	input logic RESET,
	input logic [`DATA_WIDTH-1:0] paddr,
	input logic [`DATA_WIDTH-1:0] pwdata,
	input logic pwrite,
	input logic psel,
	input logic penable,
	input logic pready,
	output logic [`DATA_WIDTH-1:0] prdata
);

	// 1 KB of word storage
	logic [`DATA_WIDTH-1:0] mem [256];

	// Log of completed write transfers
	logic [`DATA_WIDTH-1:0] logAddr [16];
	logic [`DATA_WIDTH-1:0] logData [16];
	int writeCount;

	assign prdata = mem[paddr[9:2]];

	always @(posedge Clk)
	begin
		if (RESET)
			writeCount <= 0;
		else if (psel && penable && pready && pwrite)
		begin
			mem[paddr[9:2]] <= pwdata;
			if (writeCount < 16)
			begin
				logAddr[writeCount] <= paddr;
				logData[writeCount] <= pwdata;
			end
			writeCount <= writeCount + 1;
		end
	end

endmodule

//--- verif/cpuTb.sv
`include "cpuDefs.svh"

module cpuTb
	import cpuPkg::*;
();

	localparam int ROWS = 14;
	localparam int ROW_CYCLES = 600;
	localparam int PERIOD = 40;

	// Operation codes as in op3[2:0]
	localparam logic [2:0] OP_ADD = 3'd0;
	localparam logic [2:0] OP_AND = 3'd1;
	localparam logic [2:0] OP_OR = 3'd2;
	localparam logic [2:0] OP_XOR = 3'd3;
	localparam logic [2:0] OP_SUB = 3'd4;

	// Branch kinds
	localparam logic [2:0] BR_NONE = 3'd0;
	localparam logic [2:0] BR_BA = 3'd1;
	localparam logic [2:0] BR_BN = 3'd2;
	localparam logic [2:0] BR_BE = 3'd3;
	localparam logic [2:0] BR_BNE = 3'd4;

	typedef struct packed {
		logic [2:0] op;
		logic imm;
		logic cc;
		logic [2:0] br;
		logic equal;
		logic stall;
		logic [3:0] stores;
	} testRowT;

	logic Clk = 1'b0;
	logic RESET = 1'b1;
	logic pready = 1'b1;
	logic [`DATA_WIDTH-1:0] paddr;
	logic [`DATA_WIDTH-1:0] pwdata;
	logic [`DATA_WIDTH-1:0] prdata;
	logic pwrite;
	logic psel;
	logic penable;
	logic halted;

	testRowT tests [ROWS];
	logic [15:0] lfsr = 16'd35785;
	logic stallOn = 1'b0;
	int progIdx;
	logic holdPending = 1'b0;
	logic [`DATA_WIDTH-1:0] heldAddr;
	logic firstFetch = 1'b1;
	logic haltSeen = 1'b0;

	cpuTop UUT (
		.Clk(Clk),
		.RESET(RESET),
		.paddr(paddr),
		.pwdata(pwdata),
		.pwrite(pwrite),
		.psel(psel),
		.penable(penable),
		.prdata(prdata),
		.pready(pready),
		.halted(halted)
	);

	apbMemoryModel memModel (
		.Clk(Clk),
		.RESET(RESET),
		.paddr(paddr),
		.pwdata(pwdata),
		.pwrite(pwrite),
		.psel(psel),
		.penable(penable),
		.pready(pready),
		.prdata(prdata)
	);

	always #(PERIOD / 2) Clk = ~Clk;

	// Galois LFSR, one step per bit
	function automatic logic nextBit();
		logic lsb;
		lsb = lfsr[0];
		lfsr = lfsr >> 1;
		if (lsb)
			lfsr = lfsr ^ 16'hB400;
		return lsb;
	endfunction

	function automatic logic [31:0] randWord(input int bits);
		logic [31:0] w;
		w = '0;
		for (int i = 0; i < bits; i++)
			w = {w[30:0], nextBit()};
		return w;
	endfunction

	function automatic logic [31:0] arithWord(input logic [5:0] op3, input logic [4:0] rd,
		input logic [4:0] rs1, input logic imm, input logic [4:0] rs2,
		input logic [12:0] simm);
		if (imm)
			return {2'b10, rd, op3, rs1, 1'b1, simm};
		return {2'b10, rd, op3, rs1, 1'b0, 8'h00, rs2};
	endfunction

	// Word LD or ST at r0 + simm13
	function automatic logic [31:0] memWord(input logic isStore, input logic [4:0] rd,
		input logic [12:0] offset);
		return {2'b11, rd, isStore ? 6'b000100 : 6'b000000, 5'd0, 1'b1, offset};
	endfunction

	function automatic logic [31:0] sethiWord(input logic [4:0] rd, input logic [21:0] imm22);
		return {2'b00, rd, 3'b100, imm22};
	endfunction

	function automatic logic [31:0] branchWord(input logic [3:0] cond, input logic [21:0] disp);
		return {2'b00, 1'b0, cond, 3'b010, disp};
	endfunction

	function automatic logic [31:0] expectedResult(input logic [2:0] op,
		input logic [31:0] a, input logic [31:0] b);
		case (op)
			OP_SUB: return a - b;
			OP_AND: return a & b;
			OP_OR: return a | b;
			OP_XOR: return a ^ b;
			default: return a + b;
		endcase
	endfunction

	task automatic emit(input logic [31:0] word);
		memModel.mem[progIdx] = word;
		progIdx++;
	endtask

	task automatic checkValue(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp)
		else
		begin
			$display("MISMATCH %s got 0x%08h expected 0x%08h", name, got, exp);
			$display("Finished with errors");
			$fatal;
		end
	endtask

	task automatic requireTrue(input logic ok, input string msg);
		assert (ok === 1'b1)
		else
		begin
			$display("%s", msg);
			$display("Finished with errors");
			$fatal;
		end
	endtask

	// Stall pattern, new bit each cycle
	always @(posedge Clk)
	begin
		#2;
		pready <= stallOn ? nextBit() : 1'b1;
	end

	// APB protocol and halt monitor, sampled mid cycle
	always @(negedge Clk)
	begin
		if (RESET)
		begin
			holdPending = 1'b0;
			haltSeen = 1'b0;
			firstFetch = 1'b1;
		end
		else
		begin
			requireTrue(!penable || psel, "penable was high while psel was low");
			if (holdPending)
			begin
				requireTrue(psel, "psel dropped before the transfer completed");
				checkValue("paddr", paddr, heldAddr);
			end
			holdPending = psel && !(penable && pready);
			heldAddr = paddr;
			if (firstFetch && psel)
			begin
				checkValue("first fetch paddr", paddr, `RESET_PC);
				firstFetch = 1'b0;
			end
			if (haltSeen)
				requireTrue(!psel, "bus became active after halt");
			if (halted)
				haltSeen = 1'b1;
		end
	end

	initial
	begin
		#(ROWS * ROW_CYCLES * PERIOD);
		$display("Watchdog expired before all tests completed");
		$display("Finished with errors");
		$fatal;
	end

	initial
	begin
		logic [31:0] opA;
		logic [31:0] opB;
		logic [31:0] konst;
		logic [31:0] simmBits;
		logic [12:0] simm;
		logic [3:0] cond;
		logic taken;
		logic [31:0] expAddr [$];
		logic [31:0] expData [$];
		testRowT row;

		//           op      imm   cc    br      eq    stall stores
		tests[0] = '{OP_ADD, 1'b0, 1'b0, BR_NONE, 1'b0, 1'b0, 4'd2};
		tests[1] = '{OP_SUB, 1'b0, 1'b1, BR_NONE, 1'b0, 1'b0, 4'd2};
		tests[2] = '{OP_AND, 1'b0, 1'b0, BR_NONE, 1'b0, 1'b1, 4'd2};
		tests[3] = '{OP_OR, 1'b0, 1'b1, BR_NONE, 1'b0, 1'b0, 4'd2};
		tests[4] = '{OP_XOR, 1'b0, 1'b0, BR_NONE, 1'b0, 1'b1, 4'd2};
		tests[5] = '{OP_ADD, 1'b1, 1'b1, BR_NONE, 1'b0, 1'b0, 4'd2};
		tests[6] = '{OP_SUB, 1'b1, 1'b0, BR_NONE, 1'b0, 1'b1, 4'd2};
		tests[7] = '{OP_XOR, 1'b1, 1'b0, BR_NONE, 1'b0, 1'b0, 4'd2};
		tests[8] = '{OP_ADD, 1'b0, 1'b0, BR_BE, 1'b1, 1'b0, 4'd4};
		tests[9] = '{OP_ADD, 1'b0, 1'b0, BR_BE, 1'b0, 1'b1, 4'd4};
		tests[10] = '{OP_SUB, 1'b0, 1'b0, BR_BNE, 1'b1, 1'b0, 4'd4};
		tests[11] = '{OP_SUB, 1'b0, 1'b0, BR_BNE, 1'b0, 1'b1, 4'd4};
		tests[12] = '{OP_OR, 1'b0, 1'b0, BR_BA, 1'b0, 1'b0, 4'd4};
		tests[13] = '{OP_AND, 1'b0, 1'b0, BR_BN, 1'b0, 1'b1, 4'd4};

		for (int r = 0; r < ROWS; r++)
		begin
			row = tests[r];
			@(posedge Clk);
			#1;
			opA = randWord(32);
			opB = row.equal ? opA : randWord(32);
			// Negative immediate, bit 12 set
			simmBits = randWord(12);
			simm = {1'b1, simmBits[11:0]};
			konst = randWord(32);
			stallOn = row.stall;
			#1;
			RESET = 1'b1;

			for (int i = 0; i < 256; i++)
				memModel.mem[i] = (i * 32'h0100_0193) ^ 32'hC3A5_0F1E;
			memModel.mem[64] = opA;
			memModel.mem[65] = opB;

			progIdx = 0;
			emit(memWord(1'b0, 5'd1, 13'h100));
			emit(memWord(1'b0, 5'd2, 13'h104));
			emit(arithWord({1'b0, row.cc, 1'b0, row.op}, 5'd3, 5'd1, row.imm, 5'd2, simm));
			emit(memWord(1'b1, 5'd3, 13'h200));
			emit(sethiWord(5'd4, konst[31:10]));
			emit(arithWord({3'b000, OP_OR}, 5'd4, 5'd4, 1'b1, 5'd0, {3'b000, konst[9:0]}));
			emit(memWord(1'b1, 5'd4, 13'h204));

			expAddr = {};
			expData = {};
			expAddr.push_back(32'h200);
			expData.push_back(expectedResult(row.op, opA,
				row.imm ? {{19{simm[12]}}, simm} : opB));
			expAddr.push_back(32'h204);
			expData.push_back(konst);

			if (row.br != BR_NONE)
			begin
				case (row.br)
					BR_BA: cond = 4'b1000;
					BR_BE: cond = 4'b0001;
					BR_BNE: cond = 4'b1001;
					default: cond = 4'b0000;
				endcase
				// Z is set when the SUBcc result is zero
				case (row.br)
					BR_BA: taken = 1'b1;
					BR_BE: taken = (opA - opB) == 32'd0;
					BR_BNE: taken = (opA - opB) != 32'd0;
					default: taken = 1'b0;
				endcase
				emit(arithWord(6'b000010, 5'd6, 5'd0, 1'b1, 5'd0, 13'h111));
				emit(arithWord(6'b000010, 5'd7, 5'd0, 1'b1, 5'd0, 13'h222));
				emit(arithWord(6'b010100, 5'd0, 5'd1, 1'b0, 5'd2, 13'h0));
				emit(branchWord(cond, 22'd4));
				// Delay slot
				emit(memWord(1'b1, 5'd1, 13'h208));
				emit(memWord(1'b1, 5'd6, 13'h20C));
				emit(32'h0000_0000);
				emit(memWord(1'b1, 5'd7, 13'h20C));
				expAddr.push_back(32'h208);
				expData.push_back(opA);
				expAddr.push_back(32'h20C);
				expData.push_back(taken ? 32'h222 : 32'h111);
			end
			emit(32'h0000_0000);

			repeat (4) @(posedge Clk);
			#2;
			RESET = 1'b0;
			@(negedge Clk);
			requireTrue(!psel && !penable, "bus not idle after reset");
			requireTrue(!halted, "halted high after reset");

			while (!halted)
				@(negedge Clk);
			// Halt must hold with the bus idle
			repeat (6) @(posedge Clk);
			@(negedge Clk);
			requireTrue(halted, "halted fell after UNIMP");

			checkValue("store count", memModel.writeCount, {28'd0, row.stores});
			for (int s = 0; s < expAddr.size(); s++)
			begin
				checkValue("store paddr", memModel.logAddr[s], expAddr[s]);
				checkValue("store pwdata", memModel.logData[s], expData[s]);
			end
		end

		$display("Finished with no errors");
		$finish;
	end

endmodule

//--- list.f
+incdir+source
source/cpuPkg.sv
source/apbBusMaster.sv
source/controlUnit.sv
source/regFile.sv
source/alu.sv
source/dataPath.sv
source/cpuTop.sv
verif/apbMemoryModel.sv
verif/cpuTb.sv

//--- run.sh
#!/bin/sh
# Build and run the processor testbench with Verilator

verilator --binary --timing --assert -Wall -f list.f --top-module cpuTb \
	-Mdir obj_dir -o cpuSim > build.log 2>&1
status=$?
cat build.log
if [ $status -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/cpuSim > sim.log 2>&1
status=$?
cat sim.log

if grep -q "Finished with errors" sim.log; then
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi
exit 0
